// ==== hdl/iq_types_pkg.sv ====
package iq_types_pkg;

  // width of one I or Q component at the input and output of the chain.
  localparam int SAMPLE_W = 16;

  // a full-precision mixer product is two 16x16 products summed, so one extra bit.
  localparam int WIDE_W = 33;

  // width of the unsigned fixed gain applied after the mixer.
  localparam int GAIN_W = 18;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
    logic                       last;
  } iq_beat_t;

  typedef struct packed {
    logic signed [WIDE_W-1:0] i;
    logic signed [WIDE_W-1:0] q;
    logic                     last;
  } iq_wide_beat_t;

endpackage

// ==== hdl/nco_pkg.sv ====
package nco_pkg;

  import iq_types_pkg::*;

  localparam int PHASE_W    = 24;
  localparam int LUT_ADDR_W = 10;
  localparam int TRIG_W     = 16;

  // one full turn of the oscillator is held in the table.
  localparam int  LUT_DEPTH = 2 ** LUT_ADDR_W;
  localparam real TRIG_AMP  = 32767.0;

  typedef struct packed {
    logic signed [TRIG_W-1:0] cos;
    logic signed [TRIG_W-1:0] sin;
  } trig_t;

  typedef struct packed {
    iq_beat_t              beat;
    logic [LUT_ADDR_W-1:0] idx;
  } phased_beat_t;

  typedef struct packed {
    iq_beat_t beat;
    trig_t    trig;
  } trig_beat_t;

endpackage

// ==== hdl/stream_stage.sv ====
`timescale 1ns/1ps

module stream_stage #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic i_rst,
  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,
  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  // the slot can take a new beat when it is empty or is being drained now.
  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready && i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

// ==== hdl/phase_accum.sv ====
`timescale 1ns/1ps

module phase_accum #(
  parameter logic [nco_pkg::PHASE_W-1:0] NSIG     = 40960,
  parameter logic [nco_pkg::PHASE_W-1:0] DPH_INC  = 2048,
  parameter logic [nco_pkg::PHASE_W-1:0] START_PH = 0
) (
  input  logic                     clk,
  input  logic                     i_rst,
  input  logic                     i_srst,
  input  logic                     i_valid,
  input  logic                     i_ready,
  input  iq_types_pkg::iq_beat_t   i_data,
  output nco_pkg::phased_beat_t    o_data
);

  import nco_pkg::*;

  // phase holds the value for the next beat to be accepted.
  logic [PHASE_W-1:0] phase;
  logic [PHASE_W-1:0] sample_cnt;
  logic               accept;

  assign accept = i_valid && i_ready;

  always_ff @(posedge clk) begin
    if (i_rst || i_srst) begin
      phase      <= START_PH;
      sample_cnt <= '0;
    end else if (accept) begin
      if (sample_cnt == NSIG - 1'b1) begin
        phase      <= START_PH;
        sample_cnt <= '0;
      end else begin
        phase      <= phase + DPH_INC;
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  // the table is addressed by the top bits of the phase only.
  assign o_data.beat = i_data;
  assign o_data.idx  = phase[PHASE_W-1 -: LUT_ADDR_W];

endmodule

// ==== hdl/sincos_lut.sv ====
`timescale 1ns/1ps

module sincos_lut (
  input  logic                  clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  output logic                  o_ready,
  input  nco_pkg::phased_beat_t i_data,
  output logic                  o_valid,
  input  logic                  i_ready,
  output nco_pkg::trig_beat_t   o_data
);

  import nco_pkg::*;

  localparam real PI = 3.14159265358979323846;

  trig_t      lut [LUT_DEPTH];
  trig_beat_t stage_in;

  // each entry is fixed at elaboration, rounded to the nearest integer.
  for (genvar k = 0; k < LUT_DEPTH; k++) begin : g_lut
    localparam real ANGLE = 2.0 * PI * real'(k) / real'(LUT_DEPTH);
    localparam int  COS_V = int'(TRIG_AMP * $cos(ANGLE));
    localparam int  SIN_V = int'(TRIG_AMP * $sin(ANGLE));

    assign lut[k].cos = TRIG_W'(COS_V);
    assign lut[k].sin = TRIG_W'(SIN_V);
  end

  // the index is consumed here, only the sample and its cos/sin pair go on.
  assign stage_in.beat = i_data.beat;
  assign stage_in.trig = lut[i_data.idx];

  stream_stage #(
    .T(trig_beat_t)
  ) u_stage (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_data  (stage_in),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_data  (o_data),
    .i_ready (i_ready)
  );

endmodule

// ==== hdl/complex_mixer.sv ====
`timescale 1ns/1ps

module complex_mixer (
  input  logic                        clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  output logic                        o_ready,
  input  nco_pkg::trig_beat_t         i_data,
  output logic                        o_valid,
  input  logic                        i_ready,
  output iq_types_pkg::iq_wide_beat_t o_data
);

  import iq_types_pkg::*;
  import nco_pkg::*;

  localparam int PROD_W = SAMPLE_W + TRIG_W;

  logic signed [SAMPLE_W-1:0] s_i;
  logic signed [SAMPLE_W-1:0] s_q;
  logic signed [TRIG_W-1:0]   t_cos;
  logic signed [TRIG_W-1:0]   t_sin;
  logic signed [PROD_W-1:0]   p_ic;
  logic signed [PROD_W-1:0]   p_qs;
  logic signed [PROD_W-1:0]   p_is;
  logic signed [PROD_W-1:0]   p_qc;
  iq_wide_beat_t              stage_in;

  assign s_i   = i_data.beat.i;
  assign s_q   = i_data.beat.q;
  assign t_cos = i_data.trig.cos;
  assign t_sin = i_data.trig.sin;

  assign p_ic = s_i * t_cos;
  assign p_qs = s_q * t_sin;
  assign p_is = s_i * t_sin;
  assign p_qc = s_q * t_cos;

  // the sums keep one growth bit, so nothing is dropped before scaling.
  assign stage_in.i    = WIDE_W'(p_ic) - WIDE_W'(p_qs);
  assign stage_in.q    = WIDE_W'(p_is) + WIDE_W'(p_qc);
  assign stage_in.last = i_data.beat.last;

  stream_stage #(
    .T(iq_wide_beat_t)
  ) u_stage (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_data  (stage_in),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_data  (o_data),
    .i_ready (i_ready)
  );

endmodule

// ==== hdl/scale_round_clip.sv ====
`timescale 1ns/1ps

module scale_round_clip #(
  parameter logic [iq_types_pkg::GAIN_W-1:0] SCALE       = 131071,
  parameter int unsigned                     SCALE_SHIFT = 17
) (
  input  logic                        clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  output logic                        o_ready,
  input  iq_types_pkg::iq_wide_beat_t i_data,
  output logic                        o_valid,
  input  logic                        i_ready,
  output iq_types_pkg::iq_beat_t      o_data
);

  import iq_types_pkg::*;

  // one spare bit above the product so the rounding add cannot overflow.
  localparam int PROD_W = WIDE_W + GAIN_W + 2;

  localparam logic signed [GAIN_W:0]   GAIN    = {1'b0, SCALE};
  localparam logic signed [PROD_W-1:0] RND     = {{(PROD_W-1){1'b0}}, 1'b1} << (SCALE_SHIFT + 14);
  localparam logic signed [PROD_W-1:0] SAT_MAX = (2 ** (SAMPLE_W - 1)) - 1;
  localparam logic signed [PROD_W-1:0] SAT_MIN = -(2 ** (SAMPLE_W - 1));

  iq_beat_t stage_in;

  function automatic logic signed [SAMPLE_W-1:0] round_clip(
    input logic signed [WIDE_W-1:0] x
  );
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    prod    = x * GAIN;
    shifted = (prod + RND) >>> (SCALE_SHIFT + 15);
    if (shifted > SAT_MAX) begin
      return SAT_MAX[SAMPLE_W-1:0];
    end else if (shifted < SAT_MIN) begin
      return SAT_MIN[SAMPLE_W-1:0];
    end
    return shifted[SAMPLE_W-1:0];
  endfunction

  assign stage_in.i    = round_clip(i_data.i);
  assign stage_in.q    = round_clip(i_data.q);
  assign stage_in.last = i_data.last;

  stream_stage #(
    .T(iq_beat_t)
  ) u_stage (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_data  (stage_in),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_data  (o_data),
    .i_ready (i_ready)
  );

endmodule

// ==== hdl/rx_freq_shift.sv ====
`timescale 1ns/1ps

module rx_freq_shift #(
  parameter logic [nco_pkg::PHASE_W-1:0]     NSIG        = 40960,
  parameter logic [nco_pkg::PHASE_W-1:0]     DPH_INC     = 2048,
  parameter logic [nco_pkg::PHASE_W-1:0]     START_PH    = 0,
  parameter logic [iq_types_pkg::GAIN_W-1:0] SCALE       = 131071,
  parameter int unsigned                     SCALE_SHIFT = 17
) (
  input  logic                   clk,
  input  logic                   i_rst,
  input  logic                   i_srst,
  input  logic                   i_in_valid,
  input  iq_types_pkg::iq_beat_t i_in_data,
  output logic                   o_in_ready,
  output logic                   o_out_valid,
  output iq_types_pkg::iq_beat_t o_out_data,
  input  logic                   i_out_ready
);

  import iq_types_pkg::*;
  import nco_pkg::*;

  phased_beat_t  phased;
  logic          trig_valid;
  logic          trig_ready;
  trig_beat_t    trig_data;
  logic          mix_valid;
  logic          mix_ready;
  iq_wide_beat_t mix_data;

  // the phase stage has no register, so it shares the table's ready.
  phase_accum #(
    .NSIG     (NSIG),
    .DPH_INC  (DPH_INC),
    .START_PH (START_PH)
  ) u_phase_accum (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_srst  (i_srst),
    .i_valid (i_in_valid),
    .i_ready (o_in_ready),
    .i_data  (i_in_data),
    .o_data  (phased)
  );

  sincos_lut u_sincos_lut (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_in_valid),
    .o_ready (o_in_ready),
    .i_data  (phased),
    .o_valid (trig_valid),
    .i_ready (trig_ready),
    .o_data  (trig_data)
  );

  complex_mixer u_complex_mixer (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (trig_valid),
    .o_ready (trig_ready),
    .i_data  (trig_data),
    .o_valid (mix_valid),
    .i_ready (mix_ready),
    .o_data  (mix_data)
  );

  scale_round_clip #(
    .SCALE       (SCALE),
    .SCALE_SHIFT (SCALE_SHIFT)
  ) u_scale_round_clip (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (mix_valid),
    .o_ready (mix_ready),
    .i_data  (mix_data),
    .o_valid (o_out_valid),
    .i_ready (i_out_ready),
    .o_data  (o_out_data)
  );

endmodule

// ==== tb/rx_freq_shift_properties.sv ====
`timescale 1ns/1ps

module rx_freq_shift_properties (
  input logic                   clk,
  input logic                   i_rst,
  input logic                   i_trig_valid,
  input logic                   i_mix_valid,
  input logic                   i_out_valid,
  input logic                   i_out_ready,
  input iq_types_pkg::iq_beat_t i_out_data
);

  // a stalled output beat must be held unchanged until it is taken.
  assert property (@(posedge clk) disable iff (i_rst)
    (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
    else $error("output beat changed or dropped while stalled");

  // every stage is empty in the cycle after a reset edge.
  assert property (@(posedge clk)
    i_rst |=> !(i_trig_valid || i_mix_valid || i_out_valid))
    else $error("valid high in the cycle after reset");

  assert property (@(posedge clk) disable iff (i_rst)
    i_out_valid |-> !$isunknown(i_out_data))
    else $error("unknown bits on output data while valid");

endmodule

bind rx_freq_shift rx_freq_shift_properties u_properties (
  .clk          (clk),
  .i_rst        (i_rst),
  .i_trig_valid (trig_valid),
  .i_mix_valid  (mix_valid),
  .i_out_valid  (o_out_valid),
  .i_out_ready  (i_out_ready),
  .i_out_data   (o_out_data)
);

// ==== tb/tb_rx_freq_shift.sv ====
`timescale 1ns/1ps

module tb_rx_freq_shift;

  import iq_types_pkg::*;

  localparam int          CLK_HALF       = 20;
  localparam logic [23:0] NSIG           = 8;
  // a coarse phase step so that a short frame sweeps the full circle.
  localparam logic [23:0] DPH_INC        = 24'h21_0000;
  localparam logic [23:0] START_PH       = 0;
  localparam longint      SCALE          = 131071;
  localparam int          SCALE_SHIFT    = 17;
  localparam real         PI             = 3.14159265358979323846;
  localparam int          TOTAL_BEATS    = 63;
  localparam int          TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 200;

  logic        clk = 1'b0;
  logic        i_rst;
  logic        i_srst;
  logic        i_in_valid;
  logic        o_in_ready;
  logic        o_out_valid;
  logic        i_out_ready;
  iq_beat_t    i_in_data;
  iq_beat_t    o_out_data;
  iq_beat_t    exp_q[$];
  int          cyc_q[$];
  iq_beat_t    exp_b;
  int          acc_c;
  logic [23:0] model_phase;
  logic [23:0] model_cnt;
  logic        lat_check;
  bit          bp_done;
  int          cycle = 0;
  int          sent_count = 0;
  int          out_count = 0;
  int          value_errors = 0;
  int          count_errors = 0;
  int          other_errors = 0;

  rx_freq_shift #(
    .NSIG     (NSIG),
    .DPH_INC  (DPH_INC),
    .START_PH (START_PH)
  ) u_rx_freq_shift (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_srst      (i_srst),
    .i_in_valid  (i_in_valid),
    .i_in_data   (i_in_data),
    .o_in_ready  (o_in_ready),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data),
    .i_out_ready (i_out_ready)
  );

  always #CLK_HALF clk = ~clk;

  function automatic int round_real(input real x);
    if (x >= 0.0) return $rtoi($floor(x + 0.5));
    return -$rtoi($floor(-x + 0.5));
  endfunction

  function automatic longint table_cos(input int k);
    return round_real(32767.0 * $cos(2.0 * PI * real'(k) / 1024.0));
  endfunction

  function automatic longint table_sin(input int k);
    return round_real(32767.0 * $sin(2.0 * PI * real'(k) / 1024.0));
  endfunction

  function automatic logic signed [15:0] scale_clip(input longint x);
    longint y;
    y = (x * SCALE + (longint'(1) << (SCALE_SHIFT + 14))) >>> (SCALE_SHIFT + 15);
    if (y > 32767) return 16'sh7fff;
    if (y < -32768) return 16'sh8000;
    return 16'(y);
  endfunction

  function automatic iq_beat_t expected_out(input iq_beat_t b, input logic [9:0] idx);
    longint   c;
    longint   s;
    iq_beat_t r;
    c = table_cos(int'(idx));
    s = table_sin(int'(idx));
    r.i    = scale_clip(longint'(b.i) * c - longint'(b.q) * s);
    r.q    = scale_clip(longint'(b.i) * s + longint'(b.q) * c);
    r.last = b.last;
    return r;
  endfunction

  function automatic iq_beat_t make_beat(input int i, input int q, input logic last);
    iq_beat_t b;
    b.i    = 16'(i);
    b.q    = 16'(q);
    b.last = last;
    return b;
  endfunction

  task automatic check_beat(input iq_beat_t exp, input iq_beat_t act);
    if (act.i !== exp.i) begin
      value_errors++;
      $display("** Error at %0t: o_out_data.i expected %0d, got %0d", $time, exp.i, act.i);
    end
    if (act.q !== exp.q) begin
      value_errors++;
      $display("** Error at %0t: o_out_data.q expected %0d, got %0d", $time, exp.q, act.q);
    end
    if (act.last !== exp.last) begin
      value_errors++;
      $display("** Error at %0t: o_out_data.last expected %0b, got %0b", $time, exp.last,
               act.last);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      count_errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // the reference model runs on the same edges as the DUT.
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (i_rst) begin
      model_phase = START_PH;
      model_cnt   = '0;
    end else begin
      if (o_out_valid && i_out_ready) begin
        out_count++;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("output beat at %0t arrived with no input beat pending", $time);
        end else begin
          exp_b = exp_q.pop_front();
          acc_c = cyc_q.pop_front();
          check_beat(exp_b, o_out_data);
          if (lat_check) check_count("output latency in cycles", 3, cycle - acc_c);
        end
      end
      if (i_in_valid && o_in_ready) begin
        exp_q.push_back(expected_out(i_in_data, model_phase[23:14]));
        cyc_q.push_back(cycle);
      end
      if (i_srst) begin
        model_phase = START_PH;
        model_cnt   = '0;
      end else if (i_in_valid && o_in_ready) begin
        if (model_cnt == NSIG - 1) begin
          model_phase = START_PH;
          model_cnt   = '0;
        end else begin
          model_phase = model_phase + DPH_INC;
          model_cnt   = model_cnt + 1;
        end
      end
    end
  end

  task automatic send_beat(input iq_beat_t b);
    i_in_valid <= 1'b1;
    i_in_data  <= b;
    @(posedge clk);
    while (!o_in_ready) @(posedge clk);
    sent_count++;
  endtask

  task automatic end_input();
    i_in_valid <= 1'b0;
  endtask

  // the output count is settled on the falling edge, then stimulus resumes on a rising one.
  task automatic wait_drain();
    while (out_count < sent_count) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic pulse_soft_restart();
    i_srst <= 1'b1;
    @(posedge clk);
    i_srst <= 1'b0;
  endtask

  task automatic run_single_beats();
    for (int k = 0; k < 4; k++) begin
      send_beat(make_beat($urandom, $urandom, k[0]));
      end_input();
      wait_drain();
    end
  endtask

  task automatic frame_wrap_burst();
    for (int k = 0; k < 20; k++) send_beat(make_beat($urandom, $urandom, $urandom % 2));
    end_input();
    wait_drain();
  endtask

  task automatic soft_restart_mid_frame();
    for (int k = 0; k < 3; k++) send_beat(make_beat($urandom, $urandom, 1'b0));
    end_input();
    pulse_soft_restart();
    for (int k = 0; k < 4; k++) send_beat(make_beat($urandom, $urandom, k == 3));
    end_input();
    wait_drain();
  endtask

  task automatic back_pressure_burst();
    lat_check <= 1'b0;
    bp_done = 1'b0;
    fork
      begin
        for (int k = 0; k < 24; k++) send_beat(make_beat($urandom, $urandom, $urandom % 2));
        end_input();
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          @(posedge clk);
          i_out_ready <= 1'($urandom % 2);
        end
      end
    join
    i_out_ready <= 1'b1;
    wait_drain();
    lat_check <= 1'b1;
  endtask

  // full-scale corners land near 45 and 225 degrees and must clip both ways.
  task automatic full_scale_saturation();
    pulse_soft_restart();
    for (int k = 0; k < 8; k++) begin
      case (k % 4)
        0: send_beat(make_beat(32767, 32767, 1'b0));
        1: send_beat(make_beat(-32768, -32768, 1'b0));
        2: send_beat(make_beat(32767, -32768, 1'b0));
        default: send_beat(make_beat(-32768, 32767, k == 7));
      endcase
    end
    end_input();
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'h4206_13c7));
    i_rst       = 1'b1;
    i_srst      = 1'b0;
    i_in_valid  = 1'b0;
    i_in_data   = '0;
    i_out_ready = 1'b1;
    lat_check   = 1'b1;
    repeat (4) @(posedge clk);
    i_rst <= 1'b0;
    run_single_beats();
    frame_wrap_burst();
    soft_restart_mid_frame();
    back_pressure_burst();
    full_scale_saturation();
    check_count("output beat count", sent_count, out_count);
    $display("errors: value %0d, count %0d, other %0d", value_errors, count_errors,
             other_errors);
    if (value_errors + count_errors + other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d beats pending", TIMEOUT_CYCLES,
             exp_q.size());
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/iq_types_pkg.sv
hdl/nco_pkg.sv
hdl/stream_stage.sv
hdl/phase_accum.sv
hdl/sincos_lut.sv
hdl/complex_mixer.sv
hdl/scale_round_clip.sv
hdl/rx_freq_shift.sv
tb/rx_freq_shift_properties.sv
tb/tb_rx_freq_shift.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rx_freq_shift
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
